/* hdl/afu_pkg.sv */
// Local-memory test engine package
// Shared widths, MMIO register map, command codes, status layout
// and the engine state encoding

package afu_pkg;

    // ==============================
    // Widths and bank geometry
    // ==============================
    localparam int MEM_ADDR_W   = 10;
    localparam int MEM_DATA_W   = 64;
    localparam int MMIO_ADDR_W  = 4;
    // One extra bit so a full-bank range of 1024 fits
    localparam int WORD_COUNT_W = MEM_ADDR_W + 1;
    localparam int MEM_DEPTH    = 1 << MEM_ADDR_W;

    typedef logic [MEM_ADDR_W-1:0]   mem_addr_t;
    typedef logic [MEM_DATA_W-1:0]   mem_data_t;
    typedef logic [MMIO_ADDR_W-1:0]  mmio_addr_t;
    typedef logic [WORD_COUNT_W-1:0] word_count_t;

    // Bank read pipeline and read-return tracking
    localparam int MEM_READ_LATENCY = 2;
    localparam int RD_TAG_DEPTH     = 4;
    localparam int RD_TAG_PTR_W     = $clog2(RD_TAG_DEPTH);

    // ==============================
    // MMIO register map
    // ==============================
    localparam mmio_addr_t REG_ID        = 4'd0;
    localparam mmio_addr_t REG_SEED      = 4'd1;
    localparam mmio_addr_t REG_BASE      = 4'd2;
    localparam mmio_addr_t REG_COUNT     = 4'd3;
    localparam mmio_addr_t REG_CMD       = 4'd4;
    localparam mmio_addr_t REG_STATUS    = 4'd5;
    localparam mmio_addr_t REG_FIRST_ERR = 4'd6;
    localparam mmio_addr_t REG_WIN_ADDR  = 4'd7;
    localparam mmio_addr_t REG_WIN_DATA  = 4'd8;

    localparam mem_data_t AFU_ID_VALUE = 64'h4d45_4d54_4553_5431;

    // Command codes written to REG_CMD
    localparam mem_data_t CMD_FILL  = 64'd1;
    localparam mem_data_t CMD_CHECK = 64'd2;

    // Status word layout
    localparam int STATUS_BUSY_BIT = 0;
    localparam int STATUS_DONE_BIT = 1;
    localparam int STATUS_ERR_LSB  = 16;

    typedef enum logic [1:0] {
        ENG_IDLE,
        ENG_FILL,
        ENG_CHECK_ISSUE,
        ENG_CHECK_DRAIN
    } engine_state_t;

endpackage

/* hdl/local_mem_bank.sv */
// Local memory bank
// Single-port on-chip RAM, 1024 x 64, one command per cycle.
// Reads return after a fixed two-cycle pipeline.

`timescale 1ns/1ps

module local_mem_bank
(
    input  logic              clk,
    input  logic              rst_n,
    input  logic              mem_read,
    input  logic              mem_write,
    input  afu_pkg::mem_addr_t mem_address,
    input  afu_pkg::mem_data_t mem_writedata,
    output afu_pkg::mem_data_t mem_readdata,
    output logic              mem_readdatavalid
);

    afu_pkg::mem_data_t mem_array [afu_pkg::MEM_DEPTH];

    // Read pipeline with stage 0 as the array output register
    afu_pkg::mem_data_t rd_data_pipe [afu_pkg::MEM_READ_LATENCY];
    logic [afu_pkg::MEM_READ_LATENCY-1:0] rd_valid_pipe;

    // Array write and read data stages
    always_ff @(posedge clk)
    begin
        if (mem_write)
        begin
            mem_array[mem_address] <= mem_writedata;
        end
        rd_data_pipe[0] <= mem_array[mem_address];
        for (int i = 1; i < afu_pkg::MEM_READ_LATENCY; i++)
        begin
            rd_data_pipe[i] <= rd_data_pipe[i-1];
        end
    end

    // Valid tracks the read strobe down the pipe
    always_ff @(posedge clk)
    begin
        if (!rst_n)
            rd_valid_pipe <= '0;
        else
            rd_valid_pipe <= {rd_valid_pipe[afu_pkg::MEM_READ_LATENCY-2:0], mem_read};
    end

    assign mem_readdata      = rd_data_pipe[afu_pkg::MEM_READ_LATENCY-1];
    assign mem_readdatavalid = rd_valid_pipe[afu_pkg::MEM_READ_LATENCY-1];

endmodule

/* hdl/bank_arbiter.sv */
// Bank arbiter
// Round-robin arbitration of the MMIO window and the test engine
// onto one bank port. A small owner queue steers read returns
// back to the master that issued each read.

`timescale 1ns/1ps

module bank_arbiter
(
    input  logic               clk,
    input  logic               rst_n,

    // MMIO window master
    input  logic               win_read,
    input  logic               win_write,
    input  afu_pkg::mem_addr_t win_address,
    input  afu_pkg::mem_data_t win_writedata,
    output logic               win_waitrequest,
    output logic               win_readdatavalid,
    output afu_pkg::mem_data_t win_readdata,

    // Test engine master
    input  logic               eng_read,
    input  logic               eng_write,
    input  afu_pkg::mem_addr_t eng_address,
    input  afu_pkg::mem_data_t eng_writedata,
    output logic               eng_waitrequest,
    output logic               eng_readdatavalid,
    output afu_pkg::mem_data_t eng_readdata,

    // Bank port
    output logic               mem_read,
    output logic               mem_write,
    output afu_pkg::mem_addr_t mem_address,
    output afu_pkg::mem_data_t mem_writedata,
    input  logic               mem_readdatavalid,
    input  afu_pkg::mem_data_t mem_readdata
);

    localparam int PW = afu_pkg::RD_TAG_PTR_W;

    // Owner queue where 1 marks an engine read
    logic               owner_q [afu_pkg::RD_TAG_DEPTH];
    logic [PW-1:0]      q_wr_ptr;
    logic [PW-1:0]      q_rd_ptr;
    logic [PW:0]        q_count;
    logic               q_full;
    logic               last_eng;
    logic               win_elig;
    logic               eng_elig;
    logic               grant_win;
    logic               grant_eng;

    assign q_full = (q_count == (PW+1)'(afu_pkg::RD_TAG_DEPTH));

    // Writes need no queue slot, reads do
    assign win_elig = win_write | (win_read & ~q_full);
    assign eng_elig = eng_write | (eng_read & ~q_full);

    // On contention the loser of the last round wins
    assign grant_eng = eng_elig & (~win_elig | ~last_eng);
    assign grant_win = win_elig & ~grant_eng;

    assign win_waitrequest = ~grant_win;
    assign eng_waitrequest = ~grant_eng;

    // ==============================
    // Command mux without a register stage
    // ==============================
    assign mem_read      = (grant_win & win_read)  | (grant_eng & eng_read);
    assign mem_write     = (grant_win & win_write) | (grant_eng & eng_write);
    assign mem_address   = grant_eng ? eng_address   : win_address;
    assign mem_writedata = grant_eng ? eng_writedata : win_writedata;

    // Returns come back in issue order so the queue head owns them
    assign win_readdatavalid = mem_readdatavalid & ~owner_q[q_rd_ptr];
    assign eng_readdatavalid = mem_readdatavalid &  owner_q[q_rd_ptr];
    assign win_readdata      = mem_readdata;
    assign eng_readdata      = mem_readdata;

    always_ff @(posedge clk)
    begin
        if (mem_read)
        begin
            owner_q[q_wr_ptr] <= grant_eng;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            q_wr_ptr <= '0;
            q_rd_ptr <= '0;
            q_count  <= '0;
            last_eng <= 1'b0;
        end
        else
        begin
            if (grant_win || grant_eng)
                last_eng <= grant_eng;
            if (mem_read)
                q_wr_ptr <= q_wr_ptr + 1'b1;
            if (mem_readdatavalid)
                q_rd_ptr <= q_rd_ptr + 1'b1;
            case ({mem_read, mem_readdatavalid})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

endmodule

/* hdl/mem_test_engine.sv */
// Memory test engine
// Fill writes seed + address over a word range. Check reads the
// range back with several reads in flight, counts mismatches and
// keeps the lowest failing address.

`timescale 1ns/1ps

module mem_test_engine
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  afu_pkg::mem_data_t   seed,
    input  afu_pkg::mem_addr_t   base,
    input  afu_pkg::word_count_t count,
    input  logic                 start_fill,
    input  logic                 start_check,
    output logic                 busy,
    output logic                 done,
    output afu_pkg::word_count_t err_count,
    output afu_pkg::mem_addr_t   first_err,

    output logic                 eng_read,
    output logic                 eng_write,
    output afu_pkg::mem_addr_t   eng_address,
    output afu_pkg::mem_data_t   eng_writedata,
    input  logic                 eng_waitrequest,
    input  logic                 eng_readdatavalid,
    input  afu_pkg::mem_data_t   eng_readdata
);

    afu_pkg::engine_state_t state;

    // Run parameters captured at start
    afu_pkg::mem_data_t   seed_q;
    afu_pkg::word_count_t count_q;

    // Issue side and return side run independently
    afu_pkg::word_count_t issue_cnt;
    afu_pkg::mem_addr_t   issue_addr;
    afu_pkg::word_count_t ret_cnt;
    afu_pkg::mem_addr_t   ret_addr;

    logic                 issue_last;
    logic                 ret_last;
    logic                 mismatch;

    assign busy = (state != afu_pkg::ENG_IDLE);

    assign eng_write     = (state == afu_pkg::ENG_FILL);
    assign eng_read      = (state == afu_pkg::ENG_CHECK_ISSUE);
    assign eng_address   = issue_addr;
    assign eng_writedata = seed_q + afu_pkg::mem_data_t'(issue_addr);

    assign issue_last = (issue_cnt == count_q - 1'b1);
    assign ret_last   = (ret_cnt == count_q - 1'b1);

    // Expected word for the returning address
    assign mismatch = (eng_readdata != seed_q + afu_pkg::mem_data_t'(ret_addr));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state     <= afu_pkg::ENG_IDLE;
            done      <= 1'b0;
            err_count <= '0;
            first_err <= '0;
            issue_cnt <= '0;
            ret_cnt   <= '0;
        end
        else
        begin
            case (state)
                afu_pkg::ENG_IDLE:
                begin
                    if (start_fill || start_check)
                    begin
                        done       <= (count == '0);
                        err_count  <= '0;
                        first_err  <= '0;
                        issue_cnt  <= '0;
                        ret_cnt    <= '0;
                        issue_addr <= base;
                        ret_addr   <= base;
                        seed_q     <= seed;
                        count_q    <= count;
                        // Empty range finishes at once
                        if (count != '0)
                            state <= start_fill ? afu_pkg::ENG_FILL
                                                : afu_pkg::ENG_CHECK_ISSUE;
                    end
                end

                afu_pkg::ENG_FILL,
                afu_pkg::ENG_CHECK_ISSUE:
                begin
                    if (!eng_waitrequest)
                    begin
                        issue_cnt  <= issue_cnt + 1'b1;
                        issue_addr <= issue_addr + 1'b1;
                        if (issue_last && state == afu_pkg::ENG_FILL)
                        begin
                            state <= afu_pkg::ENG_IDLE;
                            done  <= 1'b1;
                        end
                        else if (issue_last)
                        begin
                            state <= afu_pkg::ENG_CHECK_DRAIN;
                        end
                    end
                end

                default:
                begin
                    // Drain waits for the remaining returns below
                end
            endcase

            // ==============================
            // Return side of a check
            // ==============================
            if (eng_readdatavalid)
            begin
                ret_cnt  <= ret_cnt + 1'b1;
                ret_addr <= ret_addr + 1'b1;
                if (mismatch)
                begin
                    err_count <= err_count + 1'b1;
                    if (err_count == '0 || ret_addr < first_err)
                        first_err <= ret_addr;
                end
                // Last compare always lands in drain
                if (ret_last)
                begin
                    state <= afu_pkg::ENG_IDLE;
                    done  <= 1'b1;
                end
            end
        end
    end

endmodule

/* hdl/mmio_csr.sv */
// MMIO register block
// Configuration registers, command launch to the test engine,
// status readback, and a window for single-word bank access

`timescale 1ns/1ps

module mmio_csr
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 mmio_write,
    input  logic                 mmio_read,
    input  afu_pkg::mmio_addr_t  mmio_address,
    input  afu_pkg::mem_data_t   mmio_writedata,
    output afu_pkg::mem_data_t   mmio_readdata,
    output logic                 mmio_readdatavalid,

    output afu_pkg::mem_data_t   seed,
    output afu_pkg::mem_addr_t   base,
    output afu_pkg::word_count_t count,
    output logic                 start_fill,
    output logic                 start_check,
    input  logic                 busy,
    input  logic                 done,
    input  afu_pkg::word_count_t err_count,
    input  afu_pkg::mem_addr_t   first_err,

    output logic                 win_read,
    output logic                 win_write,
    output afu_pkg::mem_addr_t   win_address,
    output afu_pkg::mem_data_t   win_writedata,
    input  logic                 win_waitrequest,
    input  logic                 win_readdatavalid,
    input  afu_pkg::mem_data_t   win_readdata
);

    afu_pkg::mem_addr_t win_addr_q;
    afu_pkg::mem_data_t status;
    afu_pkg::mem_data_t reg_rdata;
    logic               start_pend;
    logic               win_data_wr;
    logic               win_data_rd;

    assign start_pend  = start_fill | start_check;
    assign win_data_wr = mmio_write && (mmio_address == afu_pkg::REG_WIN_DATA);
    assign win_data_rd = mmio_read && (mmio_address == afu_pkg::REG_WIN_DATA);

    // A launched command already counts as busy in the status word
    always_comb
    begin
        status = '0;
        status[afu_pkg::STATUS_BUSY_BIT] = busy | start_pend;
        status[afu_pkg::STATUS_DONE_BIT] = done & ~start_pend;
        status[afu_pkg::STATUS_ERR_LSB +: $bits(afu_pkg::word_count_t)] = err_count;
    end

    always_comb
    begin
        case (mmio_address)
            afu_pkg::REG_ID:        reg_rdata = afu_pkg::AFU_ID_VALUE;
            afu_pkg::REG_SEED:      reg_rdata = seed;
            afu_pkg::REG_BASE:      reg_rdata = afu_pkg::mem_data_t'(base);
            afu_pkg::REG_COUNT:     reg_rdata = afu_pkg::mem_data_t'(count);
            afu_pkg::REG_STATUS:    reg_rdata = status;
            afu_pkg::REG_FIRST_ERR: reg_rdata = afu_pkg::mem_data_t'(first_err);
            afu_pkg::REG_WIN_ADDR:  reg_rdata = afu_pkg::mem_data_t'(win_addr_q);
            default:                reg_rdata = '0;
        endcase
    end

    // ==============================
    // Control registers
    // ==============================
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            seed               <= '0;
            base               <= '0;
            count              <= '0;
            win_addr_q         <= '0;
            start_fill         <= 1'b0;
            start_check        <= 1'b0;
            win_read           <= 1'b0;
            win_write          <= 1'b0;
            mmio_readdatavalid <= 1'b0;
        end
        else
        begin
            start_fill  <= 1'b0;
            start_check <= 1'b0;

            // Window command leaves once the arbiter takes it
            if (!win_waitrequest)
            begin
                win_read  <= 1'b0;
                win_write <= 1'b0;
            end

            if (mmio_write)
            begin
                case (mmio_address)
                    afu_pkg::REG_SEED:     seed       <= mmio_writedata;
                    afu_pkg::REG_BASE:     base       <= afu_pkg::mem_addr_t'(mmio_writedata);
                    afu_pkg::REG_COUNT:    count      <= afu_pkg::word_count_t'(mmio_writedata);
                    afu_pkg::REG_WIN_ADDR: win_addr_q <= afu_pkg::mem_addr_t'(mmio_writedata);
                    afu_pkg::REG_WIN_DATA: win_write  <= 1'b1;
                    afu_pkg::REG_CMD:
                    begin
                        // Commands during a run are dropped
                        if (!busy && !start_pend)
                        begin
                            start_fill  <= (mmio_writedata == afu_pkg::CMD_FILL);
                            start_check <= (mmio_writedata == afu_pkg::CMD_CHECK);
                        end
                    end
                    default:
                    begin
                    end
                endcase
            end

            if (win_data_rd)
                win_read <= 1'b1;

            // Register reads answer next cycle, window reads on return
            mmio_readdatavalid <= (mmio_read && !win_data_rd) || win_readdatavalid;
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (win_data_wr || win_data_rd)
            win_address <= win_addr_q;
        if (win_data_wr)
            win_writedata <= mmio_writedata;

        if (win_readdatavalid)
            mmio_readdata <= win_readdata;
        else if (mmio_read)
            mmio_readdata <= reg_rdata;
    end

endmodule

/* hdl/afu_top.sv */
// Accelerator top level
// Exposes one local memory bank behind a 64-bit MMIO sink.
// The CSR window and the test engine share the bank through
// a round-robin arbiter.

`timescale 1ns/1ps

module afu_top
(
    input  logic                clk,
    input  logic                rst_n,
    input  logic                mmio_write,
    input  logic                mmio_read,
    input  afu_pkg::mmio_addr_t mmio_address,
    input  afu_pkg::mem_data_t  mmio_writedata,
    output afu_pkg::mem_data_t  mmio_readdata,
    output logic                mmio_readdatavalid
);

    // ==============================
    // Configuration and status
    // ==============================
    afu_pkg::mem_data_t   seed;
    afu_pkg::mem_addr_t   base;
    afu_pkg::word_count_t count;
    logic                 start_fill;
    logic                 start_check;
    logic                 busy;
    logic                 done;
    afu_pkg::word_count_t err_count;
    afu_pkg::mem_addr_t   first_err;

    // Window master
    logic                 win_read;
    logic                 win_write;
    afu_pkg::mem_addr_t   win_address;
    afu_pkg::mem_data_t   win_writedata;
    logic                 win_waitrequest;
    logic                 win_readdatavalid;
    afu_pkg::mem_data_t   win_readdata;

    // Engine master
    logic                 eng_read;
    logic                 eng_write;
    afu_pkg::mem_addr_t   eng_address;
    afu_pkg::mem_data_t   eng_writedata;
    logic                 eng_waitrequest;
    logic                 eng_readdatavalid;
    afu_pkg::mem_data_t   eng_readdata;

    // Bank port
    logic                 mem_read;
    logic                 mem_write;
    afu_pkg::mem_addr_t   mem_address;
    afu_pkg::mem_data_t   mem_writedata;
    logic                 mem_readdatavalid;
    afu_pkg::mem_data_t   mem_readdata;

    mmio_csr u_csr
    (
        .clk, .rst_n,
        .mmio_write, .mmio_read, .mmio_address, .mmio_writedata,
        .mmio_readdata, .mmio_readdatavalid,
        .seed, .base, .count, .start_fill, .start_check,
        .busy, .done, .err_count, .first_err,
        .win_read, .win_write, .win_address, .win_writedata,
        .win_waitrequest, .win_readdatavalid, .win_readdata
    );

    mem_test_engine u_engine
    (
        .clk, .rst_n,
        .seed, .base, .count, .start_fill, .start_check,
        .busy, .done, .err_count, .first_err,
        .eng_read, .eng_write, .eng_address, .eng_writedata,
        .eng_waitrequest, .eng_readdatavalid, .eng_readdata
    );

    bank_arbiter u_arb
    (
        .clk, .rst_n,
        .win_read, .win_write, .win_address, .win_writedata,
        .win_waitrequest, .win_readdatavalid, .win_readdata,
        .eng_read, .eng_write, .eng_address, .eng_writedata,
        .eng_waitrequest, .eng_readdatavalid, .eng_readdata,
        .mem_read, .mem_write, .mem_address, .mem_writedata,
        .mem_readdatavalid, .mem_readdata
    );

    local_mem_bank u_bank
    (
        .clk, .rst_n,
        .mem_read, .mem_write, .mem_address, .mem_writedata,
        .mem_readdata, .mem_readdatavalid
    );

endmodule

/* verif/tb_clock_gen.sv */
// Testbench clock and reset
// 4 ns clock, synchronous active-low reset held for two cycles
// and released on a falling edge

`timescale 1ns/1ps

module tb_clock_gen
(
    output logic clk,
    output logic rst_n
);

    localparam int HALF_PERIOD = 2;
    localparam int RESET_CYCLES = 2;

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release away from the sampling edge
    initial
    begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* verif/afu_tb.sv */
// Memory test engine testbench
// Table-driven MMIO test: register readback, fill and check runs,
// injected corruption, a wrapping fill and window traffic while
// the engine is busy. Stimulus is driven on the falling edge.

`timescale 1ns/1ps

module afu_tb;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,
        OP_WAIT_DONE
    } op_t;

    typedef struct {
        op_t                 op;
        afu_pkg::mmio_addr_t reg_idx;
        afu_pkg::mem_data_t  data;
        afu_pkg::mem_data_t  expect_val;
    } row_t;

    logic                clk;
    logic                rst_n;
    logic                mmio_write;
    logic                mmio_read;
    afu_pkg::mmio_addr_t mmio_address;
    afu_pkg::mem_data_t  mmio_writedata;
    afu_pkg::mem_data_t  mmio_readdata;
    logic                mmio_readdatavalid;

    row_t                rows[$];
    logic [63:0]         rng_state;
    int                  run_words = 0;
    int                  cycle_limit = 0;
    int                  cycles = 0;

    tb_clock_gen u_clk
    (
        .clk,
        .rst_n
    );

    afu_top dut_i
    (
        .clk, .rst_n,
        .mmio_write, .mmio_read, .mmio_address, .mmio_writedata,
        .mmio_readdata, .mmio_readdatavalid
    );

    // ==============================
    // Stimulus helpers
    // ==============================
    // 64-bit xorshift
    function automatic afu_pkg::mem_data_t next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 7);
        rng_state = rng_state ^ (rng_state << 17);
        return rng_state;
    endfunction

    // Fill rule of seed plus the wrapped word address
    function automatic afu_pkg::mem_data_t expected_word(input afu_pkg::mem_data_t seed,
                                                         input int addr);
        return seed + afu_pkg::mem_data_t'(addr % afu_pkg::MEM_DEPTH);
    endfunction

    function automatic afu_pkg::mem_data_t done_status(input int errs);
        afu_pkg::mem_data_t s;
        s = '0;
        s[afu_pkg::STATUS_DONE_BIT] = 1'b1;
        s[afu_pkg::STATUS_ERR_LSB +: afu_pkg::WORD_COUNT_W] = afu_pkg::word_count_t'(errs);
        return s;
    endfunction

    function automatic void stage_write(input afu_pkg::mmio_addr_t r,
                                        input afu_pkg::mem_data_t d);
        row_t row;
        row.op         = OP_WRITE;
        row.reg_idx    = r;
        row.data       = d;
        row.expect_val = '0;
        rows.push_back(row);
    endfunction

    function automatic void expect_reg(input afu_pkg::mmio_addr_t r,
                                       input afu_pkg::mem_data_t e);
        row_t row;
        row.op         = OP_READ;
        row.reg_idx    = r;
        row.data       = '0;
        row.expect_val = e;
        rows.push_back(row);
    endfunction

    // Poll status until the run ends, then compare the whole word
    function automatic void await_done(input afu_pkg::mem_data_t e);
        row_t row;
        row.op         = OP_WAIT_DONE;
        row.reg_idx    = afu_pkg::REG_STATUS;
        row.data       = '0;
        row.expect_val = e;
        rows.push_back(row);
    endfunction

    function automatic void poke_word(input int addr, input afu_pkg::mem_data_t d);
        stage_write(afu_pkg::REG_WIN_ADDR, afu_pkg::mem_data_t'(addr));
        stage_write(afu_pkg::REG_WIN_DATA, d);
    endfunction

    function automatic void peek_word(input int addr, input afu_pkg::mem_data_t e);
        stage_write(afu_pkg::REG_WIN_ADDR, afu_pkg::mem_data_t'(addr));
        expect_reg(afu_pkg::REG_WIN_DATA, e);
    endfunction

    function automatic void launch_run(input afu_pkg::mem_data_t cmd, input int words);
        stage_write(afu_pkg::REG_CMD, cmd);
        run_words += words;
    endfunction

    // ==============================
    // Stimulus table
    // ==============================
    function automatic void build_table();
        afu_pkg::mem_data_t seed_a;
        afu_pkg::mem_data_t seed_b;
        afu_pkg::mem_data_t d;
        afu_pkg::mem_data_t busy_word;
        int                 bad[3];
        int                 n;
        int                 cand;
        int                 lowest;
        logic               fresh;

        seed_a    = next_rand();
        seed_b    = next_rand();
        busy_word = afu_pkg::mem_data_t'(1) << afu_pkg::STATUS_BUSY_BIT;

        // Reset values and config readback
        expect_reg(afu_pkg::REG_STATUS, '0);
        expect_reg(afu_pkg::REG_ID, afu_pkg::AFU_ID_VALUE);
        stage_write(afu_pkg::REG_SEED, seed_a);
        stage_write(afu_pkg::REG_BASE, 64'd100);
        stage_write(afu_pkg::REG_COUNT, 64'd64);
        expect_reg(afu_pkg::REG_SEED, seed_a);
        expect_reg(afu_pkg::REG_BASE, 64'd100);
        expect_reg(afu_pkg::REG_COUNT, 64'd64);

        // Fill 100..163, then sample edges and a few random words
        launch_run(afu_pkg::CMD_FILL, 64);
        await_done(done_status(0));
        peek_word(100, expected_word(seed_a, 100));
        peek_word(163, expected_word(seed_a, 163));
        peek_word(131, expected_word(seed_a, 131));
        for (int k = 0; k < 2; k++)
        begin
            cand = 100 + int'(next_rand() % 64);
            peek_word(cand, expected_word(seed_a, cand));
        end

        // Clean check
        launch_run(afu_pkg::CMD_CHECK, 64);
        await_done(done_status(0));

        // Window traffic outside the range while a check runs
        launch_run(afu_pkg::CMD_CHECK, 64);
        expect_reg(afu_pkg::REG_STATUS, busy_word);
        d = next_rand();
        poke_word(500, d);
        peek_word(500, d);
        d = next_rand();
        poke_word(700, d);
        peek_word(700, d);
        peek_word(120, expected_word(seed_a, 120));
        expect_reg(afu_pkg::REG_STATUS, busy_word);
        await_done(done_status(0));

        // Three distinct corrupted words inside the range
        n = 0;
        lowest = 1024;
        while (n < 3)
        begin
            cand  = 100 + int'(next_rand() % 64);
            fresh = 1'b1;
            for (int j = 0; j < n; j++)
            begin
                if (bad[j] == cand)
                    fresh = 1'b0;
            end
            if (fresh)
            begin
                bad[n] = cand;
                n++;
            end
        end
        for (int k = 0; k < 3; k++)
        begin
            d = next_rand();
            // Must really differ from the fill value
            if (d == expected_word(seed_a, bad[k]))
                d = ~d;
            poke_word(bad[k], d);
            if (bad[k] < lowest)
                lowest = bad[k];
        end
        launch_run(afu_pkg::CMD_CHECK, 64);
        await_done(done_status(3));
        expect_reg(afu_pkg::REG_FIRST_ERR, afu_pkg::mem_data_t'(lowest));

        // Fill that wraps past the top of the bank
        stage_write(afu_pkg::REG_SEED, seed_b);
        stage_write(afu_pkg::REG_BASE, 64'd1000);
        stage_write(afu_pkg::REG_COUNT, 64'd48);
        launch_run(afu_pkg::CMD_FILL, 48);
        await_done(done_status(0));
        peek_word(1000, expected_word(seed_b, 1000));
        peek_word(1023, expected_word(seed_b, 1023));
        peek_word(0, expected_word(seed_b, 1024));
        peek_word(23, expected_word(seed_b, 1047));
        cand = int'(next_rand() % 24);
        peek_word(cand, expected_word(seed_b, cand + 1024));
    endfunction

    // ==============================
    // MMIO driver called on a falling edge
    // ==============================
    task automatic drive_write(input afu_pkg::mmio_addr_t r, input afu_pkg::mem_data_t d);
        mmio_write     = 1'b1;
        mmio_address   = r;
        mmio_writedata = d;
        @(negedge clk);
        mmio_write     = 1'b0;
    endtask

    // Strobe one read, wait for the reply
    task automatic fetch_reg(input afu_pkg::mmio_addr_t r, output afu_pkg::mem_data_t d);
        mmio_read    = 1'b1;
        mmio_address = r;
        @(negedge clk);
        mmio_read    = 1'b0;
        while (!mmio_readdatavalid)
            @(negedge clk);
        d = mmio_readdata;
    endtask

    task automatic report_mismatch(input int idx, input string name,
                                   input afu_pkg::mem_data_t exp_v,
                                   input afu_pkg::mem_data_t got_v);
        $display("FAILED at %0d ns: row %0d, %s expected %h, actual %h",
                 $time, idx, name, exp_v, got_v);
        $display("Result: FAILED");
        $fatal(1, "value mismatch");
    endtask

    task automatic apply_row(input row_t r, input int idx);
        afu_pkg::mem_data_t got;
        case (r.op)
            OP_WRITE:
            begin
                drive_write(r.reg_idx, r.data);
            end
            OP_READ:
            begin
                fetch_reg(r.reg_idx, got);
                assert (got === r.expect_val)
                else report_mismatch(idx, "mmio_readdata", r.expect_val, got);
            end
            default:
            begin
                // Done set and busy clear marks the end of a run
                fetch_reg(afu_pkg::REG_STATUS, got);
                while (got[afu_pkg::STATUS_DONE_BIT] !== 1'b1 ||
                       got[afu_pkg::STATUS_BUSY_BIT] !== 1'b0)
                begin
                    fetch_reg(afu_pkg::REG_STATUS, got);
                end
                assert (got === r.expect_val)
                else report_mismatch(idx, "status", r.expect_val, got);
            end
        endcase
    endtask

    // Watchdog with its limit set once the table is built
    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit)
        begin
            $display("Timeout: no progress within %0d cycles", cycle_limit);
            $display("Result: FAILED");
            $fatal(1, "timeout");
        end
    end

    initial
    begin
        mmio_write     = 1'b0;
        mmio_read      = 1'b0;
        mmio_address   = '0;
        mmio_writedata = '0;
        rng_state      = 64'd65199;
        build_table();
        cycle_limit = (run_words + rows.size()) * 4 + 500;

        @(posedge rst_n);
        @(negedge clk);
        foreach (rows[i])
        begin
            apply_row(rows[i], i);
        end

        $display("Result: PASSED");
        $finish;
    end

endmodule

/* filelist.f */
hdl/afu_pkg.sv
hdl/local_mem_bank.sv
hdl/bank_arbiter.sv
hdl/mem_test_engine.sv
hdl/mmio_csr.sv
hdl/afu_top.sv
verif/tb_clock_gen.sv
verif/afu_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := afu_tb
FILELIST  := filelist.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing -Wno-fatal

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
